/* vlog.f */
+incdir+include
verilog/fadd_pkg.sv
verilog/fadd_align.sv
verilog/fadd_add_norm.sv
verilog/fadd_round.sv
verilog/fadd_ctrl.sv
verilog/fadd_top.sv
verif/fadd_tb.sv

/* Bender.yml */
package:
  name: fadd

sources:
  - verilog/fadd_pkg.sv
  - verilog/fadd_align.sv
  - verilog/fadd_add_norm.sv
  - verilog/fadd_round.sv
  - verilog/fadd_ctrl.sv
  - verilog/fadd_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/fadd_tb.sv

/* include/fadd_tb_model.svh */
// testbench helpers whose real arithmetic is exact only for integers below 2**53
`ifndef FADD_TB_MODEL_SVH
`define FADD_TB_MODEL_SVH

// pack sign, biased exponent and fraction
function automatic logic [63:0] pack_fp(bit sign, bit [10:0] exp, bit [51:0] frac);
  return {sign, exp, frac};
endfunction

// random normal operand with the biased exponent in lo..hi
function automatic logic [63:0] normal_operand(int unsigned lo, int unsigned hi);
  bit [51:0] frac;
  bit [10:0] exp;
  frac = {20'($urandom()), $urandom()};
  exp  = 11'(lo + ($urandom() % (hi - lo + 1)));
  return pack_fp(1'($urandom()), exp, frac);
endfunction

function automatic logic [63:0] from_int(longint v);
  return $realtobits(real'(v));
endfunction

// nearest-even result as the host computes it
function automatic logic [63:0] even_sum(logic [63:0] a, logic [63:0] b, bit sub);
  real ra;
  real rb;
  ra = $bitstoreal(a);
  rb = $bitstoreal(b);
  return $realtobits(sub ? ra - rb : ra + rb);
endfunction

// rounded real sum against the exact integer sum
function automatic bit sum_inexact(longint a, longint b, bit sub);
  longint exact;
  real    r;
  exact = sub ? a - b : a + b;
  r     = sub ? real'(a) - real'(b) : real'(a) + real'(b);
  return longint'(r) != exact;
endfunction

`endif

/* verif/fadd_tb.sv */
// adder testbench whose integer stimulus stays below 2**53 and whose random exponents stay mid-range
`default_nettype none
`timescale 1ns/1ps

module fadd_tb;
  import fadd_pkg::*;

  `include "fadd_tb_model.svh"

  localparam logic [1:0] CHK_EQ    = 2'd0;
  localparam logic [1:0] CHK_TRUNC = 2'd1;
  localparam logic [1:0] CHK_PLUS  = 2'd2;
  localparam logic [1:0] CHK_MINUS = 2'd3;

  typedef struct packed {
    fp64_t       val;
    fadd_flags_t flags;
    logic        flags_on;
    logic [1:0]  kind;
    logic [31:0] cyc;
  } expect_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        in_valid;
  fadd_req_t   req;
  logic        out_valid;
  fp64_t       res;
  fadd_flags_t flags;
  logic [31:0] cyc = '0;
  expect_t     exp_q[$];

  fadd_top dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .req       (req),
    .out_valid (out_valid),
    .res       (res),
    .flags     (flags)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic abort_run(string line);
    $display("sim failed");
    $display("%s", line);
    $fatal(1);
  endtask

  task automatic report_mismatch(string what, fp64_t got, fp64_t want);
    abort_run($sformatf("FAILED at %0d ns: %s got %h expected %h", $time, what, got, want));
  endtask

  function automatic expect_t make_expect(fp64_t val, logic [1:0] kind, bit flags_on,
                                          fadd_flags_t f);
    expect_t e;
    e.val      = val;
    e.flags    = f;
    e.flags_on = flags_on;
    e.kind     = kind;
    e.cyc      = '0;
    return e;
  endfunction

  function automatic logic [1:0] dir_kind(rmode_e rm);
    case (rm)
      RM_TRUNC: return CHK_TRUNC;
      RM_PLUS:  return CHK_PLUS;
      RM_MINUS: return CHK_MINUS;
      default:  return CHK_EQ;
    endcase
  endfunction

  // signed integer below 2**53, or below 2**20 when narrow
  function automatic longint rand_int(bit narrow);
    longint m;
    m = longint'({$urandom(), $urandom()}) >> (narrow ? 44 : 11);
    return ($urandom() % 2) ? -m : m;
  endfunction

  task automatic issue(fp64_t op_a, fp64_t op_b, bit sub, rmode_e rm, expect_t e);
    fadd_req_t r;
    r.a     = op_a;
    r.b     = op_b;
    r.sub   = sub;
    r.rmode = rm;
    @(posedge clk);
    in_valid <= 1'b1;
    req      <= r;
    e.cyc = cyc;
    exp_q.push_back(e);
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  task automatic int_case(bit narrow);
    longint ia;
    longint ib;
    longint exact;
    bit     sub;
    bit     inex;
    rmode_e rm;
    fp64_t  ne;
    ia    = rand_int(narrow);
    ib    = rand_int(narrow);
    sub   = 1'($urandom());
    rm    = rmode_e'($urandom() % 4);
    exact = sub ? ia - ib : ia + ib;
    ne    = even_sum(from_int(ia), from_int(ib), sub);
    inex  = sum_inexact(ia, ib, sub);
    // cancellation to zero goes negative under RM_MINUS, +0 plus +0 does not
    if (exact == 0 && rm == RM_MINUS && (ia != 0 || sub))
      ne[63] = 1'b1;
    issue(from_int(ia), from_int(ib), sub, rm,
          make_expect(ne, inex ? dir_kind(rm) : CHK_EQ, 1'b1, fadd_flags_t'({3'b000, inex})));
  endtask

  always @(posedge clk) begin
    expect_t e;
    if (!rst && out_valid) begin
      a_in_flight: assert (exp_q.size() != 0)
        else abort_run("out_valid pulsed with no request in flight");
      e = exp_q.pop_front();
      a_latency: assert (cyc == e.cyc + 4)
        else report_mismatch("latency in cycles", 64'(cyc - e.cyc - 1), 64'(PIPE_LAT));
      case (e.kind)
        CHK_TRUNC: a_trunc: assert (res[63] == e.val[63] &&
                     (res[62:0] == e.val[62:0] || res[62:0] + 1 == e.val[62:0]))
          else report_mismatch("truncated res", res, e.val);
        CHK_PLUS: a_plus: assert ($bitstoreal(res) >= $bitstoreal(e.val))
          else report_mismatch("res below nearest-even", res, e.val);
        CHK_MINUS: a_minus: assert ($bitstoreal(res) <= $bitstoreal(e.val))
          else report_mismatch("res above nearest-even", res, e.val);
        default: a_res: assert (res == e.val)
          else report_mismatch("res", res, e.val);
      endcase
      if (e.flags_on) begin
        a_flags: assert (flags == e.flags)
          else report_mismatch("flags", 64'(flags), 64'(e.flags));
      end
    end
  end

  initial begin
    fp64_t  op_a;
    fp64_t  op_b;
    fp64_t  inf;
    fp64_t  mx;
    bit     sub;
    rmode_e rm;
    int     n;
    void'($urandom(32'h7e9b));
    rst      = 1'b1;
    in_valid = 1'b0;
    req      = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (4) begin
      @(posedge clk);
      a_idle: assert (!out_valid)
        else report_mismatch("out_valid before any request", 64'(out_valid), 64'd0);
    end

    // back-to-back burst of integer sums in all modes
    for (int i = 0; i < 40; i++)
      int_case(i % 3 == 0);
    idle(2);

    for (int i = 0; i < 60; i++) begin
      op_a = normal_operand(900, 1100);
      op_b = normal_operand(900, 1100);
      sub  = 1'($urandom());
      // same exponent and opposite effective sign
      if (i % 3 == 0)
        op_b = pack_fp(~(op_a[63] ^ sub), op_a[62:52], op_b[51:0]);
      issue(op_a, op_b, sub, RM_EVEN,
            make_expect(even_sum(op_a, op_b, sub), CHK_EQ, 1'b0, '0));
      if ($urandom() % 4 == 0)
        idle(1);
    end

    for (int i = 0; i < 60; i++) begin
      op_a = normal_operand(900, 1100);
      op_b = normal_operand(900, 1100);
      sub  = 1'($urandom());
      rm   = rmode_e'((i % 3 == 0) ? RM_TRUNC : (i % 3 == 1) ? RM_PLUS : RM_MINUS);
      issue(op_a, op_b, sub, rm,
            make_expect(even_sum(op_a, op_b, sub), dir_kind(rm), 1'b0, '0));
    end

    inf  = pack_fp(1'b0, '1, '0);
    op_a = pack_fp(1'b0, '1, 52'h1);
    issue(op_a, from_int(1), 1'b0, RM_EVEN, make_expect(QNAN, CHK_EQ, 1'b1, 4'b1000));
    issue(from_int(1), op_a, 1'b1, RM_PLUS, make_expect(QNAN, CHK_EQ, 1'b1, 4'b1000));
    issue(inf, inf, 1'b1, RM_EVEN, make_expect(QNAN, CHK_EQ, 1'b1, 4'b1000));
    issue(inf, from_int(3), 1'b0, RM_TRUNC, make_expect(inf, CHK_EQ, 1'b1, 4'b0000));
    issue(from_int(2), inf, 1'b1, RM_EVEN,
          make_expect(pack_fp(1'b1, '1, '0), CHK_EQ, 1'b1, 4'b0000));
    op_a = normal_operand(900, 1100);
    issue(op_a, op_a, 1'b1, RM_EVEN, make_expect('0, CHK_EQ, 1'b1, 4'b0000));
    issue(op_a, op_a, 1'b1, RM_MINUS,
          make_expect(pack_fp(1'b1, '0, '0), CHK_EQ, 1'b1, 4'b0000));

    mx = pack_fp(1'b0, 11'h7fe, '1);
    issue(mx, mx, 1'b0, RM_EVEN, make_expect(inf, CHK_EQ, 1'b1, 4'b0101));
    issue(mx, mx, 1'b0, RM_TRUNC, make_expect(mx, CHK_EQ, 1'b1, 4'b0101));
    // two normals one ulp apart at the bottom of the range
    op_a = pack_fp(1'b0, 11'h001, 52'h1);
    op_b = pack_fp(1'b0, 11'h001, '0);
    issue(op_a, op_b, 1'b1, RM_EVEN, make_expect('0, CHK_EQ, 1'b1, 4'b0011));
    issue(op_b, op_a, 1'b1, RM_EVEN,
          make_expect(pack_fp(1'b1, '0, '0), CHK_EQ, 1'b1, 4'b0011));
    idle(1);

    n = 0;
    while (exp_q.size() != 0 && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      abort_run("timeout while waiting for the last results to come out");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verilog/fadd_top.sv */
// three-cycle binary64 adder whose res and flags hold meaning only while out_valid is high
`default_nettype none
`timescale 1ns/1ps

module fadd_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  fadd_pkg::fadd_req_t   req,
  output logic                  out_valid,
  output fadd_pkg::fp64_t       res,
  output fadd_pkg::fadd_flags_t flags
);
  import fadd_pkg::*;

  align_t      align_s;
  norm_t       norm_s;
  rmode_e      rmode_s2;
  fp64_t       round_res;
  fadd_flags_t round_flags;

  fadd_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .req         (req),
    .rmode_s2    (rmode_s2),
    .round_res   (round_res),
    .round_flags (round_flags),
    .out_valid   (out_valid),
    .res         (res),
    .flags       (flags)
  );

  fadd_align u_align (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .stage (align_s)
  );

  fadd_add_norm u_add_norm (
    .clk      (clk),
    .rst      (rst),
    .stage_in (align_s),
    .stage    (norm_s)
  );

  fadd_round u_round (
    .clk      (clk),
    .rst      (rst),
    .stage_in (norm_s),
    .rmode    (rmode_s2),
    .res      (round_res),
    .flags    (round_flags)
  );

endmodule

`default_nettype wire

/* verilog/fadd_ctrl.sv */
// adder control where every invalid case returns the positive quiet NaN without a trap
`default_nettype none
`timescale 1ns/1ps

module fadd_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  fadd_pkg::fadd_req_t   req,
  output fadd_pkg::rmode_e      rmode_s2,
  input  fadd_pkg::fp64_t       round_res,
  input  fadd_pkg::fadd_flags_t round_flags,
  output logic                  out_valid,
  output fadd_pkg::fp64_t       res,
  output fadd_pkg::fadd_flags_t flags
);
  import fadd_pkg::*;

  logic [EXP_W-1:0]    exp_a;
  logic [EXP_W-1:0]    exp_b;
  logic                a_nan;
  logic                b_nan;
  logic                a_inf;
  logic                b_inf;
  logic                eff_sub;
  logic                sign_b;
  logic                zero_add;
  logic                inv;
  logic                spec;
  fp64_t               spec_res;
  logic [PIPE_LAT-1:0] valid_q;
  logic [PIPE_LAT-1:0] spec_q;
  logic [PIPE_LAT-1:0] inv_q;
  fp64_t               spec_res_q [PIPE_LAT];
  rmode_e              rmode_q [2];

  assign exp_a    = req.a[FRAC_W +: EXP_W];
  assign exp_b    = req.b[FRAC_W +: EXP_W];
  assign a_nan    = (exp_a == EXP_MAX) && (req.a[FRAC_W-1:0] != '0);
  assign b_nan    = (exp_b == EXP_MAX) && (req.b[FRAC_W-1:0] != '0);
  assign a_inf    = (exp_a == EXP_MAX) && (req.a[FRAC_W-1:0] == '0);
  assign b_inf    = (exp_b == EXP_MAX) && (req.b[FRAC_W-1:0] == '0);
  assign eff_sub  = req.a[SIGN_BIT] ^ req.b[SIGN_BIT] ^ req.sub;
  assign sign_b   = req.b[SIGN_BIT] ^ req.sub;
  // like-signed zeros keep their sign, unlike ones go through cancellation
  assign zero_add = (exp_a == '0) && (exp_b == '0) && !eff_sub;
  assign inv      = a_nan | b_nan | (a_inf & b_inf & eff_sub);
  assign spec     = inv | a_inf | b_inf | zero_add;

  always_comb begin
    if (inv)
      spec_res = QNAN;
    else if (a_inf)
      spec_res = {req.a[SIGN_BIT], EXP_MAX, {FRAC_W{1'b0}}};
    else if (b_inf)
      spec_res = {sign_b, EXP_MAX, {FRAC_W{1'b0}}};
    else
      spec_res = {req.a[SIGN_BIT], {SIGN_BIT{1'b0}}};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      spec_q  <= '0;
      inv_q   <= '0;
    end else begin
      valid_q <= {valid_q[PIPE_LAT-2:0], in_valid};
      spec_q  <= {spec_q[PIPE_LAT-2:0], spec};
      inv_q   <= {inv_q[PIPE_LAT-2:0], inv};
    end
  end

  always_ff @(posedge clk) begin
    spec_res_q[0] <= spec_res;
    for (int i = 1; i < PIPE_LAT; i++) begin
      spec_res_q[i] <= spec_res_q[i-1];
    end
    rmode_q[0] <= req.rmode;
    rmode_q[1] <= rmode_q[0];
  end

  // round stage reads the normalized value held in stage 2
  assign rmode_s2  = rmode_q[1];
  assign out_valid = valid_q[PIPE_LAT-1];
  assign res       = spec_q[PIPE_LAT-1] ? spec_res_q[PIPE_LAT-1] : round_res;

  always_comb begin
    flags = round_flags;
    if (spec_q[PIPE_LAT-1]) begin
      flags         = '0;
      flags.invalid = inv_q[PIPE_LAT-1];
    end
  end

  // invalid marks the quiet NaN and nothing else, rounded results included
  a_invalid_nan: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> (flags.invalid == (res == QNAN)));

endmodule

`default_nettype wire

/* verilog/fadd_round.sv */
// stage 3 of the adder where results below the normal range become signed zero
`default_nettype none
`timescale 1ns/1ps

module fadd_round (
  input  logic                  clk,
  input  logic                  rst,
  input  fadd_pkg::norm_t       stage_in,
  input  fadd_pkg::rmode_e      rmode,
  output fadd_pkg::fp64_t       res,
  output fadd_pkg::fadd_flags_t flags
);
  import fadd_pkg::*;

  logic              sign;
  logic              lsb;
  logic              grd;
  logic              rs;
  logic              inc;
  logic              carry;
  logic              ovf;
  logic              to_inf;
  logic [MANT_W:0]   rounded;
  logic [FRAC_W-1:0] frac_r;
  exp_t              exp_r;
  fp64_t             res_n;
  fadd_flags_t       flags_n;

  assign sign = stage_in.sign;
  assign lsb  = stage_in.mant[3];
  assign grd  = stage_in.mant[2];
  assign rs   = stage_in.mant[1] | stage_in.mant[0];

  always_comb begin
    case (rmode)
      RM_EVEN:  inc = grd & (rs | lsb);
      RM_PLUS:  inc = ~sign & (grd | rs);
      RM_MINUS: inc = sign & (grd | rs);
      default:  inc = 1'b0;
    endcase
  end

  assign rounded = {1'b0, stage_in.mant[XMANT_W-2:3]} + {{MANT_W{1'b0}}, inc};
  // all ones rounded up, the fraction is zero either way
  assign carry   = rounded[MANT_W];
  assign frac_r  = carry ? rounded[FRAC_W:1] : rounded[FRAC_W-1:0];
  assign exp_r   = stage_in.exp + exp_t'(carry);
  assign ovf     = exp_r >= exp_t'(EXP_MAX);
  assign to_inf  = (rmode == RM_EVEN) || (rmode == RM_PLUS && !sign) ||
                   (rmode == RM_MINUS && sign);

  always_comb begin
    flags_n = '0;
    if (stage_in.zero) begin
      res_n = {rmode == RM_MINUS, {SIGN_BIT{1'b0}}};
    end else if (stage_in.exp == '0) begin
      res_n = {sign, {SIGN_BIT{1'b0}}};
      flags_n.underflow = 1'b1;
      flags_n.inexact   = 1'b1;
    end else if (ovf) begin
      res_n = to_inf ? {sign, EXP_MAX, {FRAC_W{1'b0}}}
                     : {sign, EXP_MAX - 1'b1, {FRAC_W{1'b1}}};
      flags_n.overflow = 1'b1;
      flags_n.inexact  = 1'b1;
    end else begin
      res_n = {sign, exp_r[EXP_W-1:0], frac_r};
      flags_n.inexact = grd | rs;
    end
  end

  always_ff @(posedge clk) begin
    res <= res_n;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else begin
      flags <= flags_n;
    end
  end

endmodule

`default_nettype wire

/* verilog/fadd_add_norm.sv */
// stage 2 of the adder which clamps the exponent at zero when cancellation goes below normal
`default_nettype none
`timescale 1ns/1ps

module fadd_add_norm (
  input  logic              clk,
  input  logic              rst,
  input  fadd_pkg::align_t  stage_in,
  output fadd_pkg::norm_t   stage
);
  import fadd_pkg::*;

  xmant_t sum;
  xmant_t mant_n;
  exp_t   exp_n;
  shamt_t lz;
  logic   carry;
  logic   sum_zero;

  // smaller operand never exceeds the larger one, so no borrow out
  assign sum = stage_in.eff_sub ? stage_in.big - stage_in.smaller
                                : stage_in.big + stage_in.smaller;
  assign carry    = sum[XMANT_W-1];
  assign sum_zero = (sum == '0);

  // leading one below the carry bit
  always_comb begin
    lz = '0;
    for (int i = 0; i < XMANT_W - 1; i++) begin
      if (sum[i]) begin
        lz = shamt_t'(XMANT_W - 2 - i);
      end
    end
  end

  always_comb begin
    if (carry) begin
      // one place right, old round and sticky fold together
      mant_n = {1'b0, sum[XMANT_W-1:2], sum[1] | sum[0]};
      exp_n  = stage_in.exp + 1'b1;
    end else begin
      mant_n = sum << lz;
      // zero exponent is the flush case for stage 3
      if (stage_in.exp > exp_t'(lz)) begin
        exp_n = stage_in.exp - exp_t'(lz);
      end else begin
        exp_n = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    stage.mant <= mant_n;
    stage.exp  <= exp_n;
    stage.sign <= stage_in.sign;
    stage.zero <= sum_zero;
  end

  // any nonzero sum comes out with its hidden bit in place
  a_hidden_bit: assert property (@(posedge clk) disable iff (rst)
    (!$isunknown(stage_in) && !sum_zero) |=> stage.mant[XMANT_W-2]);

endmodule

`default_nettype wire

/* verilog/fadd_align.sv */
// stage 1 of the adder where an exponent field of zero is read as a zero significand
`default_nettype none
`timescale 1ns/1ps

module fadd_align (
  input  logic                clk,
  input  logic                rst,
  input  fadd_pkg::fadd_req_t req,
  output fadd_pkg::align_t    stage
);
  import fadd_pkg::*;

  logic [EXP_W-1:0] exp_a;
  logic [EXP_W-1:0] exp_b;
  logic [EXP_W-1:0] exp_big;
  logic [EXP_W-1:0] exp_small;
  logic [EXP_W-1:0] exp_diff;
  mant_t            mant_a;
  mant_t            mant_b;
  logic             a_more;
  logic             sign_b;
  logic             sticky;
  shamt_t           shamt;
  xmant_t           big_x;
  xmant_t           small_x;
  xmant_t           small_sh;
  xmant_t           lost_mask;

  assign exp_a  = req.a[FRAC_W +: EXP_W];
  assign exp_b  = req.b[FRAC_W +: EXP_W];
  assign mant_a = (exp_a == '0) ? '0 : {1'b1, req.a[FRAC_W-1:0]};
  assign mant_b = (exp_b == '0) ? '0 : {1'b1, req.b[FRAC_W-1:0]};

  // exponent then fraction, one unsigned compare
  assign a_more = req.a[SIGN_BIT-1:0] >= req.b[SIGN_BIT-1:0];
  assign sign_b = req.b[SIGN_BIT] ^ req.sub;

  assign exp_big   = a_more ? exp_a : exp_b;
  assign exp_small = a_more ? exp_b : exp_a;
  assign big_x     = {1'b0, a_more ? mant_a : mant_b, 3'b000};
  assign small_x   = {1'b0, a_more ? mant_b : mant_a, 3'b000};
  assign exp_diff  = exp_big - exp_small;

  // past 56 places everything is sticky anyway
  assign shamt     = (exp_diff > SHIFT_MAX) ? shamt_t'(SHIFT_MAX) : exp_diff[SHAMT_W-1:0];
  assign lost_mask = ~({XMANT_W{1'b1}} << shamt);
  assign small_sh  = small_x >> shamt;
  assign sticky    = |(small_x & lost_mask);

  always_ff @(posedge clk) begin
    stage.exp     <= {1'b0, exp_big};
    stage.big     <= big_x;
    stage.smaller <= {small_sh[XMANT_W-1:1], small_sh[0] | sticky};
    stage.sign    <= a_more ? req.a[SIGN_BIT] : sign_b;
    stage.eff_sub <= req.a[SIGN_BIT] ^ req.b[SIGN_BIT] ^ req.sub;
  end

  // a nonzero smaller operand survives the shift through its sticky bit
  a_shift_sticky: assert property (@(posedge clk) disable iff (rst)
    (!$isunknown(req) && (small_x != '0)) |=> (stage.smaller != '0));

endmodule

`default_nettype wire

/* verilog/fadd_pkg.sv */
// binary64 adder types with denormal inputs and tiny results flushed to zero
`default_nettype none

package fadd_pkg;

  localparam int EXP_W     = 11;
  localparam int FRAC_W    = 52;
  localparam int SIGN_BIT  = EXP_W + FRAC_W;
  localparam int MANT_W    = FRAC_W + 1;
  // one carry bit above, guard round and sticky below
  localparam int XMANT_W   = MANT_W + 4;
  localparam int SHIFT_MAX = XMANT_W - 1;
  localparam int SHAMT_W   = $clog2(SHIFT_MAX + 1);
  localparam int PIPE_LAT  = 3;

  localparam logic [EXP_W-1:0] EXP_MAX = '1;

  typedef logic [SIGN_BIT:0]  fp64_t;
  typedef logic [EXP_W:0]     exp_t;
  typedef logic [MANT_W-1:0]  mant_t;
  typedef logic [XMANT_W-1:0] xmant_t;
  typedef logic [SHAMT_W-1:0] shamt_t;

  localparam fp64_t QNAN = {1'b0, EXP_MAX, 1'b1, {(FRAC_W-1){1'b0}}};

  typedef enum logic [1:0] {
    RM_TRUNC,
    RM_EVEN,
    RM_PLUS,
    RM_MINUS
  } rmode_e;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic inexact;
  } fadd_flags_t;

  typedef struct packed {
    fp64_t  a;
    fp64_t  b;
    logic   sub;
    rmode_e rmode;
  } fadd_req_t;

  // stage 1 to stage 2
  typedef struct packed {
    exp_t   exp;
    xmant_t big;
    xmant_t smaller;
    logic   sign;
    logic   eff_sub;
  } align_t;

  // stage 2 to stage 3
  typedef struct packed {
    xmant_t mant;
    exp_t   exp;
    logic   sign;
    logic   zero;
  } norm_t;

endpackage

`default_nettype wire
